/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = ace_rd_tb
FILELIST = verilog.f
LOG      = sim.log
PASS_MSG = NO ERRORS

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* src/ace_rd_ctrl.sv */
// ACE read-port controller, one transaction in flight at a time
// AXI sideband (LOCK, CACHE, PROT, QOS, REGION, USER) is not carried
// Request, snoop, fetch and response stages in a chain

`timescale 1ns/1ps
`default_nettype none

module ace_rd_ctrl (
    input  logic                 ACLK,
    input  logic                 ARESETn,
    // Master AR and R
    input  ace_rd_pkg::ar_req_t  ar,
    input  logic                 ar_valid,
    output logic                 ar_ready,
    output ace_rd_pkg::r_beat_t  r,
    output logic                 r_valid,
    input  logic                 r_ready,
    // Snoop AC, CR and CD
    output ace_rd_pkg::ac_req_t  ac,
    output logic                 ac_valid,
    input  logic                 ac_ready,
    input  logic [4:0]           cr,
    input  logic                 cr_valid,
    output logic                 cr_ready,
    input  ace_rd_pkg::cd_beat_t cd,
    input  logic                 cd_valid,
    output logic                 cd_ready,
    // Memory AR and R
    output ace_rd_pkg::mem_ar_t  mem_ar,
    output logic                 mem_ar_valid,
    input  logic                 mem_ar_ready,
    input  ace_rd_pkg::mem_r_t   mem_r,
    input  logic                 mem_r_valid,
    output logic                 mem_r_ready
);
    import ace_rd_pkg::*;

    // ============================================================
    // Stage-to-stage channels
    // ============================================================
    rd_req_t snp_req;
    logic    snp_req_valid;
    logic    snp_req_ready;
    rd_req_t fetch_req;
    logic    fetch_req_valid;
    logic    fetch_req_ready;
    rd_req_t miss_req;
    logic    miss_req_valid;
    logic    miss_req_ready;
    r_beat_t err_beat;
    logic    err_beat_valid;
    logic    err_beat_ready;
    r_beat_t snp_beat;
    logic    snp_beat_valid;
    logic    snp_beat_ready;
    r_beat_t mem_beat;
    logic    mem_beat_valid;
    logic    mem_beat_ready;
    logic    txn_done;

    // Port names match the channel names above
    ace_rd_req_stage   i_req   (.*);
    ace_rd_snoop_stage i_snoop (.*);
    ace_rd_fetch_stage i_fetch (.*);
    ace_rd_resp_stage  i_resp  (.*);

endmodule

`default_nettype wire

/* src/ace_rd_fetch_stage.sv */
// Reads one full line from memory for a direct request or a snoop miss
// Beats go out with the request ID; IsShared and PassDirty are always clear

`timescale 1ns/1ps
`default_nettype none

module ace_rd_fetch_stage (
    input  logic                ACLK,
    input  logic                ARESETn,
    input  ace_rd_pkg::rd_req_t fetch_req,
    input  logic                fetch_req_valid,
    output logic                fetch_req_ready,
    input  ace_rd_pkg::rd_req_t miss_req,
    input  logic                miss_req_valid,
    output logic                miss_req_ready,
    output ace_rd_pkg::mem_ar_t mem_ar,
    output logic                mem_ar_valid,
    input  logic                mem_ar_ready,
    input  ace_rd_pkg::mem_r_t  mem_r,
    input  logic                mem_r_valid,
    output logic                mem_r_ready,
    output ace_rd_pkg::r_beat_t mem_beat,
    output logic                mem_beat_valid,
    input  logic                mem_beat_ready
);
    import ace_rd_pkg::*;

    typedef enum logic [1:0] {
        FET_IDLE,
        FET_ADDR,
        FET_DATA
    } fet_state_e;

    fet_state_e state_q;
    mem_ar_t    mem_ar_q;
    rd_req_t    src;
    logic       take;

    // Direct fetch wins, though both are never valid together
    assign fetch_req_ready = (state_q == FET_IDLE);
    assign miss_req_ready  = (state_q == FET_IDLE) && !fetch_req_valid;
    assign take = (fetch_req_valid && fetch_req_ready) || (miss_req_valid && miss_req_ready);
    assign src  = fetch_req_valid ? fetch_req : miss_req;

    always_ff @(posedge ACLK) begin
        if (take) begin
            mem_ar_q <= '{id: src.id, addr: src.addr, len: AR_LEN_LINE,
                          size: AR_SIZE_WORD, burst: BURST_INCR};
        end
    end

    assign mem_ar         = mem_ar_q;
    assign mem_ar_valid   = (state_q == FET_ADDR);
    assign mem_r_ready    = (state_q == FET_DATA) && mem_beat_ready;
    assign mem_beat_valid = (state_q == FET_DATA) && mem_r_valid;
    assign mem_beat       = '{id: mem_ar_q.id, data: mem_r.data,
                              resp: {2'b00, mem_r.resp}, last: mem_r.last};

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            state_q <= FET_IDLE;
        end else begin
            case (state_q)
                FET_IDLE: if (take) state_q <= FET_ADDR;
                FET_ADDR: if (mem_ar_ready) state_q <= FET_DATA;
                FET_DATA: begin
                    if (mem_r_valid && mem_r_ready && mem_r.last) begin
                        state_q <= FET_IDLE;
                    end
                end
                default:  state_q <= FET_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/ace_rd_pkg.sv */
// Shared widths, ACE codes and channel payloads for the read controller
// Line size is fixed at 16 words of 32 bits and the ID is a single bit

`default_nettype none

package ace_rd_pkg;

    // ============================================================
    // Widths and fixed AR encodings
    // ============================================================
    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int ID_W       = 1;
    localparam int LINE_BEATS = 16;

    localparam logic [7:0] AR_LEN_LINE  = 8'd15;
    localparam logic [2:0] AR_SIZE_WORD = 3'd2;
    localparam logic [1:0] BURST_INCR   = 2'd1;

    // Bit positions inside CRRESP
    localparam int CR_DATA_BIT       = 0;
    localparam int CR_PASS_DIRTY_BIT = 2;
    localparam int CR_IS_SHARED_BIT  = 3;

    // ============================================================
    // Codes
    // ============================================================
    typedef enum logic [1:0] {
        NON_SHAREABLE = 2'd0,
        INNER         = 2'd1,
        OUTER         = 2'd2,
        SYSTEM        = 2'd3
    } ace_domain_e;

    typedef enum logic [3:0] {
        SNP_READ_NO_SNOOP = 4'b0000,
        SNP_READ_SHARED   = 4'b0001,
        SNP_READ_UNIQUE   = 4'b0111,
        SNP_MAKE_UNIQUE   = 4'b1100,
        SNP_MAKE_INVALID  = 4'b1101
    } ace_snoop_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_EXOKAY = 2'd1,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } axi_resp_e;

    typedef enum logic [2:0] {
        KIND_NO_SNOOP,
        KIND_READ_SHARED,
        KIND_READ_UNIQUE,
        KIND_MAKE_UNIQUE,
        KIND_UNSUPPORTED
    } rd_kind_e;

    // ============================================================
    // Channel payloads
    // ============================================================
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        ace_domain_e       domain;
        ace_snoop_e        snoop;
    } ar_req_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        rd_kind_e          kind;
    } rd_req_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } mem_ar_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        axi_resp_e         resp;
        logic              last;
    } mem_r_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        ace_snoop_e        snoop;
    } ac_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } cd_beat_t;

    // resp is {IsShared, PassDirty, axi_resp_e}
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [3:0]        resp;
        logic              last;
    } r_beat_t;

endpackage

`default_nettype wire

/* src/ace_rd_req_stage.sv */
// Takes one master AR at a time and holds off the next until txn_done
// Only INNER and OUTER domains are snooped, SYSTEM is rejected

`timescale 1ns/1ps
`default_nettype none

module ace_rd_req_stage (
    input  logic                ACLK,
    input  logic                ARESETn,
    input  ace_rd_pkg::ar_req_t ar,
    input  logic                ar_valid,
    output logic                ar_ready,
    output ace_rd_pkg::rd_req_t snp_req,
    output logic                snp_req_valid,
    input  logic                snp_req_ready,
    output ace_rd_pkg::rd_req_t fetch_req,
    output logic                fetch_req_valid,
    input  logic                fetch_req_ready,
    output ace_rd_pkg::r_beat_t err_beat,
    output logic                err_beat_valid,
    input  logic                err_beat_ready,
    input  logic                txn_done
);
    import ace_rd_pkg::*;

    rd_kind_e kind_in;
    rd_req_t  req_q;
    logic     busy_q;
    logic     pend_q;
    logic     routed;

    // Classify straight from the AR payload
    always_comb begin
        kind_in = KIND_UNSUPPORTED;
        if (ar.domain == NON_SHAREABLE && ar.snoop == SNP_READ_NO_SNOOP) begin
            kind_in = KIND_NO_SNOOP;
        end else if (ar.domain == INNER || ar.domain == OUTER) begin
            case (ar.snoop)
                SNP_READ_SHARED: kind_in = KIND_READ_SHARED;
                SNP_READ_UNIQUE: kind_in = KIND_READ_UNIQUE;
                SNP_MAKE_UNIQUE: kind_in = KIND_MAKE_UNIQUE;
                default:         kind_in = KIND_UNSUPPORTED;
            endcase
        end
    end

    assign ar_ready = !busy_q;

    always_ff @(posedge ACLK) begin
        if (ar_valid && ar_ready) begin
            req_q <= '{id: ar.id, addr: ar.addr, kind: kind_in};
        end
    end

    // Exactly one output carries the request
    assign snp_req         = req_q;
    assign fetch_req       = req_q;
    assign snp_req_valid   = pend_q && (req_q.kind inside {KIND_READ_SHARED, KIND_READ_UNIQUE,
                                                            KIND_MAKE_UNIQUE});
    assign fetch_req_valid = pend_q && (req_q.kind == KIND_NO_SNOOP);
    assign err_beat_valid  = pend_q && (req_q.kind == KIND_UNSUPPORTED);
    assign err_beat        = '{id: req_q.id, data: '0, resp: {2'b00, RESP_DECERR}, last: 1'b1};

    assign routed = (snp_req_valid && snp_req_ready) || (fetch_req_valid && fetch_req_ready) ||
                    (err_beat_valid && err_beat_ready);

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            busy_q <= 1'b0;
            pend_q <= 1'b0;
        end else if (ar_valid && ar_ready) begin
            busy_q <= 1'b1;
            pend_q <= 1'b1;
        end else begin
            if (txn_done) begin
                busy_q <= 1'b0;
            end
            if (routed) begin
                pend_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* src/ace_rd_resp_stage.sv */
// One-entry output register for the master R channel
// Assumes at most one source is valid in any cycle

`timescale 1ns/1ps
`default_nettype none

module ace_rd_resp_stage (
    input  logic                ACLK,
    input  logic                ARESETn,
    input  ace_rd_pkg::r_beat_t err_beat,
    input  logic                err_beat_valid,
    output logic                err_beat_ready,
    input  ace_rd_pkg::r_beat_t snp_beat,
    input  logic                snp_beat_valid,
    output logic                snp_beat_ready,
    input  ace_rd_pkg::r_beat_t mem_beat,
    input  logic                mem_beat_valid,
    output logic                mem_beat_ready,
    output ace_rd_pkg::r_beat_t r,
    output logic                r_valid,
    input  logic                r_ready,
    output logic                txn_done
);
    import ace_rd_pkg::*;

    r_beat_t r_q;
    r_beat_t in_beat;
    logic    r_valid_q;
    logic    in_valid;
    logic    in_ready;

    // Free when empty or draining this cycle
    assign in_ready       = !r_valid_q || r_ready;
    assign err_beat_ready = in_ready;
    assign snp_beat_ready = in_ready;
    assign mem_beat_ready = in_ready;

    assign in_valid = err_beat_valid || snp_beat_valid || mem_beat_valid;

    always_comb begin
        if (err_beat_valid) begin
            in_beat = err_beat;
        end else if (snp_beat_valid) begin
            in_beat = snp_beat;
        end else begin
            in_beat = mem_beat;
        end
    end

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            r_valid_q <= 1'b0;
        end else if (in_ready) begin
            r_valid_q <= in_valid;
        end
    end

    always_ff @(posedge ACLK) begin
        if (in_valid && in_ready) begin
            r_q <= in_beat;
        end
    end

    assign r        = r_q;
    assign r_valid  = r_valid_q;
    assign txn_done = r_valid_q && r_ready && r_q.last;

endmodule

`default_nettype wire

/* src/ace_rd_snoop_stage.sv */
// Snoops the other cache for the shareable reads
// MakeUnique is issued on AC as MakeInvalid
// CD data is passed through beat by beat, so cd_ready tracks the response stage

`timescale 1ns/1ps
`default_nettype none

module ace_rd_snoop_stage (
    input  logic                 ACLK,
    input  logic                 ARESETn,
    input  ace_rd_pkg::rd_req_t  snp_req,
    input  logic                 snp_req_valid,
    output logic                 snp_req_ready,
    output ace_rd_pkg::ac_req_t  ac,
    output logic                 ac_valid,
    input  logic                 ac_ready,
    input  logic [4:0]           cr,
    input  logic                 cr_valid,
    output logic                 cr_ready,
    input  ace_rd_pkg::cd_beat_t cd,
    input  logic                 cd_valid,
    output logic                 cd_ready,
    output ace_rd_pkg::rd_req_t  miss_req,
    output logic                 miss_req_valid,
    input  logic                 miss_req_ready,
    output ace_rd_pkg::r_beat_t  snp_beat,
    output logic                 snp_beat_valid,
    input  logic                 snp_beat_ready
);
    import ace_rd_pkg::*;

    typedef enum logic [2:0] {
        SNP_IDLE,
        SNP_ADDR,
        SNP_RESP,
        SNP_DATA,
        SNP_MISS,
        SNP_CMPL
    } snp_state_e;

    snp_state_e state_q;
    snp_state_e state_d;
    rd_req_t    req_q;
    logic [4:0] cr_q;
    ace_snoop_e snp_code;
    logic [3:0] snp_resp;

    always_comb begin
        case (req_q.kind)
            KIND_READ_SHARED: snp_code = SNP_READ_SHARED;
            KIND_READ_UNIQUE: snp_code = SNP_READ_UNIQUE;
            default:          snp_code = SNP_MAKE_INVALID;
        endcase
    end

    assign snp_resp = {cr_q[CR_IS_SHARED_BIT], cr_q[CR_PASS_DIRTY_BIT], RESP_OKAY};

    // ============================================================
    // Channel drive
    // ============================================================
    assign snp_req_ready  = (state_q == SNP_IDLE);
    assign ac_valid       = (state_q == SNP_ADDR);
    assign ac             = '{addr: req_q.addr, snoop: snp_code};
    assign cr_ready       = (state_q == SNP_RESP);
    assign cd_ready       = (state_q == SNP_DATA) && snp_beat_ready;
    assign miss_req_valid = (state_q == SNP_MISS);
    assign miss_req       = req_q;
    assign snp_beat_valid = ((state_q == SNP_DATA) && cd_valid) || (state_q == SNP_CMPL);

    // Dataless MakeUnique completion is one zero beat
    always_comb begin
        if (state_q == SNP_DATA) begin
            snp_beat = '{id: req_q.id, data: cd.data, resp: snp_resp, last: cd.last};
        end else begin
            snp_beat = '{id: req_q.id, data: '0, resp: snp_resp, last: 1'b1};
        end
    end

    // ============================================================
    // FSM
    // ============================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            SNP_IDLE: if (snp_req_valid) state_d = SNP_ADDR;
            SNP_ADDR: if (ac_ready) state_d = SNP_RESP;
            SNP_RESP: begin
                if (cr_valid) begin
                    if (cr[CR_DATA_BIT]) begin
                        state_d = SNP_DATA;
                    end else if (req_q.kind == KIND_MAKE_UNIQUE) begin
                        state_d = SNP_CMPL;
                    end else begin
                        state_d = SNP_MISS;
                    end
                end
            end
            SNP_DATA: if (cd_valid && cd_ready && cd.last) state_d = SNP_IDLE;
            SNP_MISS: if (miss_req_ready) state_d = SNP_IDLE;
            SNP_CMPL: if (snp_beat_ready) state_d = SNP_IDLE;
            default:  state_d = SNP_IDLE;
        endcase
    end

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            state_q <= SNP_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge ACLK) begin
        if (snp_req_valid && snp_req_ready) begin
            req_q <= snp_req;
        end
        if (cr_valid && cr_ready) begin
            cr_q <= cr;
        end
    end

endmodule

`default_nettype wire

/* verif/ace_rd_tb.sv */
// Self-checking testbench for the ACE read controller
// Memory and snooped-cache models answer after random delays from a fixed seed
// Eight directed requests, then a random mix under R back-pressure

`timescale 1ns/1ps
`default_nettype none

module ace_rd_tb;
    import ace_rd_pkg::*;

    localparam int NUM_TXN      = 150;
    localparam int NUM_DIRECTED = 8;
    localparam int AR_TIMEOUT   = 200;
    localparam int TXN_TIMEOUT  = 2000;

    logic       ACLK;
    logic       ARESETn;
    ar_req_t    ar;
    logic       ar_valid;
    logic       ar_ready;
    r_beat_t    r;
    logic       r_valid;
    logic       r_ready;
    ac_req_t    ac;
    logic       ac_valid;
    logic       ac_ready;
    logic [4:0] cr;
    logic       cr_valid;
    logic       cr_ready;
    cd_beat_t   cd;
    logic       cd_valid;
    logic       cd_ready;
    mem_ar_t    mem_ar;
    logic       mem_ar_valid;
    logic       mem_ar_ready;
    mem_r_t     mem_r;
    logic       mem_r_valid;
    logic       mem_r_ready;

    int seed = 32'h878a_6fb9;

    // Stimulus side
    int        cd_shown;
    int        mem_shown;
    axi_resp_e mem_resp_pick;
    bit        timed_out;

    ace_domain_e dir_dom [NUM_DIRECTED] = '{NON_SHAREABLE, INNER, OUTER, INNER,
                                            OUTER, SYSTEM, NON_SHAREABLE, INNER};
    ace_snoop_e  dir_snp [NUM_DIRECTED] = '{SNP_READ_NO_SNOOP, SNP_READ_SHARED,
                                            SNP_READ_UNIQUE, SNP_MAKE_UNIQUE,
                                            SNP_MAKE_UNIQUE, SNP_READ_SHARED,
                                            SNP_READ_UNIQUE, SNP_MAKE_INVALID};

    // Scoreboard and model progress kept by the monitor
    r_beat_t     exp_q[$];
    ar_req_t     cur;
    rd_kind_e    cur_kind;
    string       tname = "reset";
    bit          txn_open = 1'b0;
    bit          ac_seen = 1'b0;
    bit          mem_allowed = 1'b0;
    bit          cr_pend = 1'b0;
    logic [31:0] cd_addr = '0;
    int          cd_idx = 0;
    int          cd_left = 0;
    logic [31:0] mem_addr = '0;
    logic        mem_id = 1'b0;
    axi_resp_e   mem_resp = RESP_OKAY;
    int          mem_idx = 0;
    int          mem_left = 0;
    int          ar_count = 0;
    int          done_count = 0;
    int          mismatch_errs = 0;
    int          other_errs = 0;

    ace_rd_ctrl i_dut (.*);

    initial begin
        ACLK = 1'b0;
        forever #4 ACLK = ~ACLK;
    end

    // ============================================================
    // Reference rules
    // ============================================================
    function automatic rd_kind_e predict_kind(input ar_req_t req);
        if (req.domain == NON_SHAREABLE && req.snoop == SNP_READ_NO_SNOOP) begin
            return KIND_NO_SNOOP;
        end
        if (req.domain != INNER && req.domain != OUTER) begin
            return KIND_UNSUPPORTED;
        end
        case (req.snoop)
            SNP_READ_SHARED: return KIND_READ_SHARED;
            SNP_READ_UNIQUE: return KIND_READ_UNIQUE;
            SNP_MAKE_UNIQUE: return KIND_MAKE_UNIQUE;
            default:         return KIND_UNSUPPORTED;
        endcase
    endfunction

    function automatic bit is_snooped(input rd_kind_e kind);
        return kind inside {KIND_READ_SHARED, KIND_READ_UNIQUE, KIND_MAKE_UNIQUE};
    endfunction

    // MakeUnique goes out as MakeInvalid
    function automatic ace_snoop_e snoop_code_for(input rd_kind_e kind);
        if (kind == KIND_READ_SHARED) return SNP_READ_SHARED;
        if (kind == KIND_READ_UNIQUE) return SNP_READ_UNIQUE;
        return SNP_MAKE_INVALID;
    endfunction

    function automatic int rand_int(input int n);
        int v;
        v = $random(seed) & 32'h7fff_ffff;
        return v % n;
    endfunction

    // One pick in six is a raw 4-bit code
    function automatic ace_snoop_e pick_snoop();
        int k;
        k = rand_int(6);
        case (k)
            0:       return SNP_READ_NO_SNOOP;
            1:       return SNP_READ_SHARED;
            2:       return SNP_READ_UNIQUE;
            3:       return SNP_MAKE_UNIQUE;
            4:       return SNP_MAKE_INVALID;
            default: return ace_snoop_e'(4'(rand_int(16)));
        endcase
    endfunction

    // ============================================================
    // Compare tasks
    // ============================================================
    task automatic check_beat(input string name, input r_beat_t exp, input r_beat_t act);
        if (act !== exp) begin
            mismatch_errs++;
            $display("MISMATCH %s R beat expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_mem_ar(input string name, input mem_ar_t exp, input mem_ar_t act);
        if (act !== exp) begin
            mismatch_errs++;
            $display("MISMATCH %s memory AR expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_ac(input string name, input ac_req_t exp, input ac_req_t act);
        if (act !== exp) begin
            mismatch_errs++;
            $display("MISMATCH %s AC expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic push_line_beats(input logic id, input logic [31:0] base,
                                   input logic [3:0] resp);
        r_beat_t b;
        for (int i = 0; i < LINE_BEATS; i++) begin
            b = '{id: id, data: base + 32'(i), resp: resp, last: (i == LINE_BEATS - 1)};
            exp_q.push_back(b);
        end
    endtask

    // ============================================================
    // Monitor sampled on the rising edge
    // ============================================================
    task automatic check_reset_outputs();
        if (ar_ready !== 1'b1 || r_valid !== 1'b0 || ac_valid !== 1'b0 ||
            cr_ready !== 1'b0 || cd_ready !== 1'b0 || mem_ar_valid !== 1'b0 ||
            mem_r_ready !== 1'b0) begin
            other_errs++;
            $display("Control outputs are not in their idle state after reset");
        end
    endtask

    task automatic observe_request();
        r_beat_t err;
        if (txn_open && ar_ready) begin
            other_errs++;
            $display("ar_ready is high while %s is still open", tname);
        end
        if (ar_valid && ar_ready) begin
            cur         = ar;
            cur_kind    = predict_kind(ar);
            tname       = $sformatf("txn %0d %s", ar_count, cur_kind.name());
            txn_open    = 1'b1;
            ac_seen     = 1'b0;
            mem_allowed = (cur_kind == KIND_NO_SNOOP);
            ar_count++;
            if (cur_kind == KIND_UNSUPPORTED) begin
                err = '{id: ar.id, data: '0, resp: {2'b00, RESP_DECERR}, last: 1'b1};
                exp_q.push_back(err);
            end
        end
    endtask

    task automatic observe_snoop();
        ac_req_t    exp_ac;
        r_beat_t    zero;
        logic [3:0] snp_resp;
        if (ac_valid && ac_ready) begin
            if (!is_snooped(cur_kind) || ac_seen) begin
                other_errs++;
                $display("%s: a snoop was issued where none belongs", tname);
            end else begin
                exp_ac = '{addr: cur.addr, snoop: snoop_code_for(cur_kind)};
                check_ac(tname, exp_ac, ac);
            end
            ac_seen = 1'b1;
            cd_addr = ac.addr;
            cr_pend = 1'b1;
        end
        if (cr_valid && cr_ready) begin
            cr_pend  = 1'b0;
            snp_resp = {cr[CR_IS_SHARED_BIT], cr[CR_PASS_DIRTY_BIT], RESP_OKAY};
            if (cr[CR_DATA_BIT]) begin
                push_line_beats(cur.id, ~cur.addr, snp_resp);
                cd_idx  = 0;
                cd_left = LINE_BEATS;
            end else if (cur_kind == KIND_MAKE_UNIQUE) begin
                zero = '{id: cur.id, data: '0, resp: snp_resp, last: 1'b1};
                exp_q.push_back(zero);
            end else begin
                mem_allowed = 1'b1;
            end
        end
        if (cd_valid && cd_ready) begin
            cd_idx++;
            cd_left--;
        end
    endtask

    task automatic observe_memory();
        mem_ar_t exp_ar;
        if (mem_ar_valid && mem_ar_ready) begin
            if (!mem_allowed) begin
                other_errs++;
                $display("%s: a memory read was issued where none belongs", tname);
            end else begin
                exp_ar = '{id: cur.id, addr: cur.addr, len: AR_LEN_LINE,
                           size: AR_SIZE_WORD, burst: BURST_INCR};
                check_mem_ar(tname, exp_ar, mem_ar);
                push_line_beats(cur.id, cur.addr, {2'b00, mem_resp_pick});
            end
            mem_allowed = 1'b0;
            mem_addr    = mem_ar.addr;
            mem_id      = mem_ar.id;
            mem_resp    = mem_resp_pick;
            mem_idx     = 0;
            mem_left    = LINE_BEATS;
        end
        if (mem_r_valid && mem_r_ready) begin
            mem_idx++;
            mem_left--;
        end
    endtask

    task automatic observe_response();
        r_beat_t exp_beat;
        if (r_valid && r_ready) begin
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("%s: an R beat arrived when none was expected", tname);
            end else begin
                exp_beat = exp_q.pop_front();
                check_beat(tname, exp_beat, r);
            end
            if (r.last) begin
                if (exp_q.size() != 0) begin
                    other_errs++;
                    $display("%s: ended with %0d beats still expected", tname, exp_q.size());
                    exp_q.delete();
                end
                if (is_snooped(cur_kind) && !ac_seen) begin
                    other_errs++;
                    $display("%s: completed without a snoop", tname);
                end
                txn_open = 1'b0;
                done_count++;
            end
        end
    endtask

    initial begin : monitor
        bit reset_checked;
        reset_checked = 1'b0;
        forever begin
            @(posedge ACLK);
            if (ARESETn) begin
                if (!reset_checked) begin
                    check_reset_outputs();
                    reset_checked = 1'b1;
                end
                observe_request();
                observe_snoop();
                observe_memory();
                observe_response();
            end
        end
    end

    // ============================================================
    // Stimulus and models driven on the falling edge
    // ============================================================
    task automatic drive_models();
        r_ready      = rand_int(4) != 0;
        ac_ready     = rand_int(3) == 0;
        mem_ar_ready = rand_int(3) == 0;
        // New CR bits only while no response is pending
        if (!cr_pend) begin
            cr_valid             = 1'b0;
            cr                   = '0;
            cr[CR_DATA_BIT]      = rand_int(2) == 0;
            cr[CR_PASS_DIRTY_BIT] = rand_int(2) == 0;
            cr[CR_IS_SHARED_BIT] = rand_int(2) == 0;
        end else if (!cr_valid) begin
            cr_valid = rand_int(2) == 0;
        end
        if (cd_left == 0) begin
            cd_valid = 1'b0;
        end else if (!cd_valid || cd_shown != cd_idx) begin
            cd_shown = cd_idx;
            cd.data  = ~cd_addr + 32'(cd_idx);
            cd.last  = (cd_idx == LINE_BEATS - 1);
            cd_valid = rand_int(3) != 0;
        end
        // Memory resp is picked once per line while idle
        if (mem_left == 0) begin
            mem_r_valid   = 1'b0;
            mem_resp_pick = (rand_int(2) == 0) ? RESP_OKAY : RESP_SLVERR;
        end else if (!mem_r_valid || mem_shown != mem_idx) begin
            mem_shown   = mem_idx;
            mem_r.id    = mem_id;
            mem_r.data  = mem_addr + 32'(mem_idx);
            mem_r.resp  = mem_resp;
            mem_r.last  = (mem_idx == LINE_BEATS - 1);
            mem_r_valid = rand_int(3) != 0;
        end
    endtask

    task automatic next_cycle();
        @(negedge ACLK);
        drive_models();
    endtask

    task automatic run_request(input int n);
        int t;
        if (n < NUM_DIRECTED) begin
            ar.domain = dir_dom[n];
            ar.snoop  = dir_snp[n];
        end else begin
            ar.domain = ace_domain_e'(2'(rand_int(4)));
            ar.snoop  = pick_snoop();
        end
        ar.id    = 1'(rand_int(2));
        ar.addr  = $random(seed) & 32'hffff_fffc;
        ar_valid = 1'b1;
        t = 0;
        while (ar_count <= n && t < AR_TIMEOUT) begin
            next_cycle();
            t++;
        end
        ar_valid = 1'b0;
        if (ar_count <= n) begin
            timed_out = 1'b1;
            $display("Timeout: request %0d was never accepted on AR", n);
        end else begin
            t = 0;
            while (done_count <= n && t < TXN_TIMEOUT) begin
                next_cycle();
                t++;
            end
            if (done_count <= n) begin
                timed_out = 1'b1;
                $display("Timeout: request %0d never received its last R beat", n);
            end
        end
    endtask

    initial begin : stimulus
        ARESETn       = 1'b0;
        ar            = '0;
        ar_valid      = 1'b0;
        r_ready       = 1'b0;
        ac_ready      = 1'b0;
        cr            = '0;
        cr_valid      = 1'b0;
        cd            = '0;
        cd_valid      = 1'b0;
        mem_ar_ready  = 1'b0;
        mem_r         = '0;
        mem_r_valid   = 1'b0;
        cd_shown      = -1;
        mem_shown     = -1;
        mem_resp_pick = RESP_OKAY;
        timed_out     = 1'b0;
        // Three rising edges in reset, release on the next falling edge
        repeat (3) @(posedge ACLK);
        next_cycle();
        ARESETn = 1'b1;
        for (int n = 0; n < NUM_TXN && !timed_out; n++) begin
            run_request(n);
        end
        $display("Mismatches: %0d, other errors: %0d, timeouts: %0d",
                 mismatch_errs, other_errs, timed_out);
        if (timed_out || mismatch_errs != 0 || other_errs != 0) begin
            $display("ERRORS FOUND");
        end else begin
            $display("NO ERRORS");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
src/ace_rd_pkg.sv
src/ace_rd_req_stage.sv
src/ace_rd_snoop_stage.sv
src/ace_rd_fetch_stage.sv
src/ace_rd_resp_stage.sv
src/ace_rd_ctrl.sv
verif/ace_rd_tb.sv
